/* Bender.yml */
package:
  name: wb_subsys

sources:
  - rtl/wb_ic_pkg.sv
  - rtl/wb_ic_arbiter.sv
  - rtl/wb_decode_err_target.sv
  - rtl/wb_ram_target.sv
  - rtl/wb_ic_1x2.sv
  - rtl/wb_subsys_top.sv
  - target: simulation
    files:
      - sim/wb_ic_props.sv
      - sim/tb_wb_subsys.sv

/* compile.f */
rtl/wb_ic_pkg.sv
rtl/wb_ic_arbiter.sv
rtl/wb_decode_err_target.sv
rtl/wb_ram_target.sv
rtl/wb_ic_1x2.sv
rtl/wb_subsys_top.sv
sim/wb_ic_props.sv
sim/tb_wb_subsys.sv

/* rtl/wb_decode_err_target.sv */
/*
 * Decode-error target, answers each strobe with a one-cycle ERR
 * and returns zero read data
 */
`timescale 1ns/1ps

module wb_decode_err_target (
	input  logic                               clk,
	input  logic                               rstn,
	input  logic                               cyc_i,
	input  logic                               stb_i,
	output logic                               err_o,
	output logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_o
);

	import wb_ic_pkg::*;

	// Nothing to read from an unmapped address
	assign dat_o = '0;

	// One ERR per strobe
	// a strobe still held during ERR is not answered twice
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_o <= 1'b0;
		end else begin
			err_o <= cyc_i && stb_i && !err_o;
		end
	end

endmodule

/* rtl/wb_ic_1x2.sv */
/*
 * One-master, two-target Wishbone pass-through interconnect
 * Address decode, route FSM, per-route arbiters, request and response muxes
 * Unmapped addresses go to an internal decode-error target
 */
`timescale 1ns/1ps

module wb_ic_1x2 (
	input  logic                               clk,
	input  logic                               rstn,
	// Master side
	input  logic                               cyc_i,
	input  logic                               stb_i,
	input  logic                               we_i,
	input  logic [wb_ic_pkg::WB_ADDR_WIDTH-1:0] adr_i,
	input  logic [wb_ic_pkg::WB_SEL_WIDTH-1:0]  sel_i,
	input  logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_i,
	output logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_o,
	output logic                               ack_o,
	output logic                               err_o,
	// Target 0
	output logic                               t0_cyc_o,
	output logic                               t0_stb_o,
	output logic                               t0_we_o,
	output logic [wb_ic_pkg::WB_ADDR_WIDTH-1:0] t0_adr_o,
	output logic [wb_ic_pkg::WB_SEL_WIDTH-1:0]  t0_sel_o,
	output logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] t0_wdat_o,
	input  logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] t0_rdat_i,
	input  logic                               t0_ack_i,
	// Target 1
	output logic                               t1_cyc_o,
	output logic                               t1_stb_o,
	output logic                               t1_we_o,
	output logic [wb_ic_pkg::WB_ADDR_WIDTH-1:0] t1_adr_o,
	output logic [wb_ic_pkg::WB_SEL_WIDTH-1:0]  t1_sel_o,
	output logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] t1_wdat_o,
	input  logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] t1_rdat_i,
	input  logic                               t1_ack_i
);

	import wb_ic_pkg::*;

	// Mapped targets plus the error route
	localparam int N_ROUTES = N_TARGETS + 1;

	typedef enum logic {IDLE, BUSY} state_t;

	state_t                  state_q;
	logic [ROUTE_BITS-1:0]   route_q;
	logic                    gnt     [N_ROUTES];
	logic                    on      [N_ROUTES];
	logic [WB_DATA_WIDTH-1:0] s_rdat [N_ROUTES];
	logic                    e_err;
	logic [WB_DATA_WIDTH-1:0] e_rdat;

	// Inclusive window compare, anything else is the error route
	function automatic logic [ROUTE_BITS-1:0] addr2route(input logic [WB_ADDR_WIDTH-1:0] adr);
		if (adr >= T0_BASE && adr <= T0_LIMIT) begin
			return ROUTE_BITS'(0);
		end
		if (adr >= T1_BASE && adr <= T1_LIMIT) begin
			return ROUTE_BITS'(1);
		end
		return ROUTE_BITS'(N_TARGETS);
	endfunction

	// Route FSM, captures the decode on a fresh strobe
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= IDLE;
			route_q <= NO_ROUTE;
		end else begin
			case (state_q)
				IDLE: begin
					if (cyc_i && stb_i) begin
						state_q <= BUSY;
						route_q <= addr2route(adr_i);
					end
				end
				BUSY: begin
					// Done on either response, or if the master abandons the cycle
					if (ack_o || err_o || !cyc_i) begin
						state_q <= IDLE;
						route_q <= NO_ROUTE;
					end
				end
				default: begin
					state_q <= IDLE;
					route_q <= NO_ROUTE;
				end
			endcase
		end
	end

	// One arbiter per route, request is route equality
	for (genvar r = 0; r < N_ROUTES; r++) begin : g_route
		wb_ic_arbiter #(
			.N_REQ (1)
		) i_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (route_q == ROUTE_BITS'(r)),
			.gnt_o    (gnt[r]),
			.gnt_id_o ()
		);

		// Route is live only when selected and granted
		assign on[r] = (route_q == ROUTE_BITS'(r)) && gnt[r];
	end

	// Request mux towards the RAM targets
	assign t0_cyc_o  = on[0] && cyc_i;
	assign t0_stb_o  = on[0] && stb_i;
	assign t0_we_o   = on[0] && we_i;
	assign t0_adr_o  = on[0] ? adr_i : '0;
	assign t0_sel_o  = on[0] ? sel_i : '0;
	assign t0_wdat_o = on[0] ? dat_i : '0;

	assign t1_cyc_o  = on[1] && cyc_i;
	assign t1_stb_o  = on[1] && stb_i;
	assign t1_we_o   = on[1] && we_i;
	assign t1_adr_o  = on[1] ? adr_i : '0;
	assign t1_sel_o  = on[1] ? sel_i : '0;
	assign t1_wdat_o = on[1] ? dat_i : '0;

	// Decode-fail path, needs only the strobe
	wb_decode_err_target i_err (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (on[N_TARGETS] && cyc_i),
		.stb_i (on[N_TARGETS] && stb_i),
		.err_o (e_err),
		.dat_o (e_rdat)
	);

	// Read data sources per route
	assign s_rdat[0]         = t0_rdat_i;
	assign s_rdat[1]         = t1_rdat_i;
	assign s_rdat[N_TARGETS] = e_rdat;

	// Read data back to the master, zero when no route is live
	always_comb begin
		dat_o = '0;
		for (int r = 0; r < N_ROUTES; r++) begin
			if (on[r]) begin
				dat_o = dat_o | s_rdat[r];
			end
		end
	end

	// RAM targets have no ERR line, the error target no ACK
	assign ack_o = (on[0] && t0_ack_i) || (on[1] && t1_ack_i);
	assign err_o = on[N_TARGETS] && e_err;

endmodule

/* rtl/wb_ic_arbiter.sv */
/*
 * Round-robin arbiter with registered grant and grant identifier
 * Grant is held until the granted request drops
 */
`timescale 1ns/1ps

module wb_ic_arbiter #(
	parameter int N_REQ = 1
) (
	input  logic                                       clk,
	input  logic                                       rstn,
	input  logic [N_REQ-1:0]                           req_i,
	output logic                                       gnt_o,
	output logic [((N_REQ > 1) ? $clog2(N_REQ) : 1)-1:0] gnt_id_o
);

	// Identifier width, one bit minimum
	localparam int ID_BITS = (N_REQ > 1) ? $clog2(N_REQ) : 1;

	logic               found_hi;
	logic               found_lo;
	logic [ID_BITS-1:0] pick_hi;
	logic [ID_BITS-1:0] pick_lo;

	// Scan from the top so the lowest match wins
	// pick_hi is the lowest requester above the last grant
	always_comb begin
		found_hi = 1'b0;
		found_lo = 1'b0;
		pick_hi  = '0;
		pick_lo  = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				found_lo = 1'b1;
				pick_lo  = ID_BITS'(i);
				if (ID_BITS'(i) > gnt_id_o) begin
					found_hi = 1'b1;
					pick_hi  = ID_BITS'(i);
				end
			end
		end
	end

	// gnt_id_o doubles as the last granted requester
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			gnt_id_o <= '0;
		end else if (gnt_o) begin
			// Release once the owner lets go
			if (!req_i[gnt_id_o]) begin
				gnt_o <= 1'b0;
			end
		end else if (found_lo) begin
			gnt_o    <= 1'b1;
			gnt_id_o <= found_hi ? pick_hi : pick_lo;
		end
	end

endmodule

/* rtl/wb_ic_pkg.sv */
/*
 * Shared Wishbone bus widths, address map of the two RAM windows
 * and route numbering of the 1x2 interconnect
 */
package wb_ic_pkg;

	// Bus widths
	localparam int WB_ADDR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = 32;
	localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

	// Mapped targets, the error route sits at index N_TARGETS
	localparam int N_TARGETS = 2;

	// Route number covers both targets plus the error route
	localparam int ROUTE_BITS = $clog2(N_TARGETS + 1);

	// Idle route value
	localparam logic [ROUTE_BITS-1:0] NO_ROUTE = {ROUTE_BITS{1'b1}};

	// Target 0 window, inclusive
	localparam logic [WB_ADDR_WIDTH-1:0] T0_BASE  = 32'h0000_0000;
	localparam logic [WB_ADDR_WIDTH-1:0] T0_LIMIT = 32'h0000_03FF;

	// Target 1 window, inclusive
	localparam logic [WB_ADDR_WIDTH-1:0] T1_BASE  = 32'h0000_1000;
	localparam logic [WB_ADDR_WIDTH-1:0] T1_LIMIT = 32'h0000_10FF;

	// RAM depths in words, each fills its window
	localparam int T0_WORDS = 256;
	localparam int T1_WORDS = 64;

endpackage

/* rtl/wb_ram_target.sv */
/*
 * Word-wide RAM target with byte-select writes,
 * registered read data and a single-cycle ACK
 */
`timescale 1ns/1ps

module wb_ram_target #(
	parameter int WORDS = 256
) (
	input  logic                               clk,
	input  logic                               rstn,
	input  logic                               cyc_i,
	input  logic                               stb_i,
	input  logic                               we_i,
	input  logic [$clog2(WORDS)-1:0]           adr_i,
	input  logic [wb_ic_pkg::WB_SEL_WIDTH-1:0]  sel_i,
	input  logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_i,
	output logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_o,
	output logic                               ack_o
);

	import wb_ic_pkg::*;

	logic [WB_DATA_WIDTH-1:0] mem [WORDS];
	logic                     access;

	// New access only when no ACK is outstanding
	assign access = cyc_i && stb_i && !ack_o;

	// Response handshake
	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

	// Storage and read register
	always_ff @(posedge clk) begin
		if (access) begin
			if (we_i) begin
				// Merge only the selected bytes
				for (int b = 0; b < WB_SEL_WIDTH; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end else begin
				dat_o <= mem[adr_i];
			end
		end
	end

endmodule

/* rtl/wb_subsys_top.sv */
/*
 * Wishbone subsystem top, interconnect with two RAM targets
 */
`timescale 1ns/1ps

module wb_subsys_top (
	input  logic                               clk,
	input  logic                               rstn,
	input  logic                               cyc_i,
	input  logic                               stb_i,
	input  logic                               we_i,
	input  logic [wb_ic_pkg::WB_ADDR_WIDTH-1:0] adr_i,
	input  logic [wb_ic_pkg::WB_SEL_WIDTH-1:0]  sel_i,
	input  logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_i,
	output logic [wb_ic_pkg::WB_DATA_WIDTH-1:0] dat_o,
	output logic                               ack_o,
	output logic                               err_o
);

	import wb_ic_pkg::*;

	// Word index widths of each window
	localparam int T0_IDX = $clog2(T0_WORDS);
	localparam int T1_IDX = $clog2(T1_WORDS);

	logic                     t0_cyc, t0_stb, t0_we, t0_ack;
	logic [WB_ADDR_WIDTH-1:0] t0_adr;
	logic [WB_SEL_WIDTH-1:0]  t0_sel;
	logic [WB_DATA_WIDTH-1:0] t0_wdat, t0_rdat;
	logic                     t1_cyc, t1_stb, t1_we, t1_ack;
	logic [WB_ADDR_WIDTH-1:0] t1_adr;
	logic [WB_SEL_WIDTH-1:0]  t1_sel;
	logic [WB_DATA_WIDTH-1:0] t1_wdat, t1_rdat;

	wb_ic_1x2 i_ic (
		.clk       (clk),
		.rstn      (rstn),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.adr_i     (adr_i),
		.sel_i     (sel_i),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.err_o     (err_o),
		.t0_cyc_o  (t0_cyc),
		.t0_stb_o  (t0_stb),
		.t0_we_o   (t0_we),
		.t0_adr_o  (t0_adr),
		.t0_sel_o  (t0_sel),
		.t0_wdat_o (t0_wdat),
		.t0_rdat_i (t0_rdat),
		.t0_ack_i  (t0_ack),
		.t1_cyc_o  (t1_cyc),
		.t1_stb_o  (t1_stb),
		.t1_we_o   (t1_we),
		.t1_adr_o  (t1_adr),
		.t1_sel_o  (t1_sel),
		.t1_wdat_o (t1_wdat),
		.t1_rdat_i (t1_rdat),
		.t1_ack_i  (t1_ack)
	);

	// Byte address bits 1:0 dropped, window offset gives the word index
	wb_ram_target #(.WORDS(T0_WORDS)) i_ram0 (
		.clk (clk), .rstn (rstn), .cyc_i (t0_cyc), .stb_i (t0_stb), .we_i (t0_we),
		.adr_i (t0_adr[T0_IDX+1:2]), .sel_i (t0_sel), .dat_i (t0_wdat),
		.dat_o (t0_rdat), .ack_o (t0_ack)
	);

	wb_ram_target #(.WORDS(T1_WORDS)) i_ram1 (
		.clk (clk), .rstn (rstn), .cyc_i (t1_cyc), .stb_i (t1_stb), .we_i (t1_we),
		.adr_i (t1_adr[T1_IDX+1:2]), .sel_i (t1_sel), .dat_i (t1_wdat),
		.dat_o (t1_rdat), .ack_o (t1_ack)
	);

endmodule

/* sim/tb_wb_subsys.sv */
/*
 * Testbench for the Wishbone subsystem
 * Clock, reset, directed and random transactions, reference model,
 * compare process and watchdog
 */
`timescale 1ns/1ps

module tb_wb_subsys;

	import wb_ic_pkg::*;

	localparam int N_FILL     = T0_WORDS + T1_WORDS;
	localparam int N_DIRECTED = 40;
	localparam int N_RANDOM   = 200;
	// Fill, directed, random and the final read sweep
	localparam int N_TXN      = 2 * N_FILL + N_DIRECTED + N_RANDOM;
	localparam int RESET_CYC  = 5;
	localparam int CLK_NS     = 4;
	localparam int RESP_MAX   = 20;
	// Drive edge, then three cycles from the sampled strobe to the response
	localparam int FIRST_LAT  = 1 + 3;

	logic                     clk   = 1'b0;
	logic                     rstn  = 1'b0;
	logic                     cyc_i = 1'b0;
	logic                     stb_i = 1'b0;
	logic                     we_i  = 1'b0;
	logic [WB_ADDR_WIDTH-1:0] adr_i = '0;
	logic [WB_SEL_WIDTH-1:0]  sel_i = '0;
	logic [WB_DATA_WIDTH-1:0] dat_i = '0;
	logic [WB_DATA_WIDTH-1:0] dat_o;
	logic                     ack_o;
	logic                     err_o;

	integer                   seed   = 94;
	int                       errors = 0;
	logic [WB_DATA_WIDTH-1:0] model0 [T0_WORDS];
	logic [WB_DATA_WIDTH-1:0] model1 [T1_WORDS];

	// Expected and observed response of the current transaction
	logic [WB_ADDR_WIDTH-1:0] cur_adr;
	logic [WB_DATA_WIDTH-1:0] exp_dat, obs_dat;
	logic                     exp_err, obs_ack, obs_err, chk_dat, chk_lat;
	int                       obs_lat;
	event                     resp_ev;

	wb_subsys_top i_dut (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.we_i  (we_i),
		.adr_i (adr_i),
		.sel_i (sel_i),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.ack_o (ack_o),
		.err_o (err_o)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// Byte-lane merge of a write into a stored word
	function automatic logic [WB_DATA_WIDTH-1:0] merge_bytes(
		input logic [WB_DATA_WIDTH-1:0] old_w,
		input logic [WB_DATA_WIDTH-1:0] new_w,
		input logic [WB_SEL_WIDTH-1:0]  sel);
		logic [WB_DATA_WIDTH-1:0] res;
		res = old_w;
		for (int b = 0; b < WB_SEL_WIDTH; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Reference model, updates the window arrays
	// Unmapped addresses give ERR, zero data and no model change
	function automatic void ref_access(
		input  logic [WB_ADDR_WIDTH-1:0] adr,
		input  logic                     we,
		input  logic [WB_SEL_WIDTH-1:0]  sel,
		input  logic [WB_DATA_WIDTH-1:0] wdat,
		output logic [WB_DATA_WIDTH-1:0] rdat,
		output logic                     is_err);
		int idx;
		rdat   = '0;
		is_err = 1'b0;
		if (adr >= T0_BASE && adr <= T0_LIMIT) begin
			idx = (adr - T0_BASE) >> 2;
			if (we) begin
				model0[idx] = merge_bytes(model0[idx], wdat, sel);
			end
			rdat = model0[idx];
		end else if (adr >= T1_BASE && adr <= T1_LIMIT) begin
			idx = (adr - T1_BASE) >> 2;
			if (we) begin
				model1[idx] = merge_bytes(model1[idx], wdat, sel);
			end
			rdat = model1[idx];
		end else begin
			is_err = 1'b1;
		end
	endfunction

	// One classic cycle, entered and left right after a rising edge
	task automatic bus_access(
		input logic [WB_ADDR_WIDTH-1:0] adr,
		input logic                     we,
		input logic [WB_SEL_WIDTH-1:0]  sel,
		input logic [WB_DATA_WIDTH-1:0] wdat,
		input logic                     check_lat);
		int cycles;
		ref_access(adr, we, sel, wdat, exp_dat, exp_err);
		cur_adr = adr;
		chk_dat = !we || exp_err;
		chk_lat = check_lat;
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i  <= we;
		adr_i <= adr;
		sel_i <= sel;
		dat_i <= wdat;
		cycles = 0;
		// Outputs sampled mid-cycle
		do begin
			@(negedge clk);
			cycles++;
		end while (!(ack_o || err_o) && cycles < RESP_MAX);
		if (ack_o || err_o) begin
			obs_dat = dat_o;
			obs_ack = ack_o;
			obs_err = err_o;
			obs_lat = cycles;
			->resp_ev;
		end else begin
			$display("No response from the DUT within %0d cycles for address %h",
				RESP_MAX, adr);
			errors++;
		end
		@(posedge clk);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i  <= 1'b0;
		sel_i <= '0;
		@(negedge clk);
		if (ack_o || err_o) begin
			$display("Second response seen after the strobe dropped, address %h", adr);
			errors++;
		end
		@(posedge clk);
	endtask

	// Region pick, then a word inside it or anywhere in the address space
	task automatic random_access();
		logic [31:0] pick, r, adr, dat;
		pick = $random(seed);
		r    = $random(seed);
		dat  = $random(seed);
		case (pick[1:0])
			2'd0:    adr = T0_BASE + (r % T0_WORDS) * 4 + pick[3:2];
			2'd1:    adr = T1_BASE + (r % T1_WORDS) * 4 + pick[3:2];
			default: adr = r;
		endcase
		bus_access(adr, pick[4], pick[8:5], dat, 1'b0);
	endtask

	// Compare process
	always @(resp_ev) begin
		if (obs_ack && obs_err) begin
			$display("ERROR %0t: ack and err together at address %h", $time, cur_adr);
			errors++;
		end
		if (obs_err != exp_err || obs_ack != !exp_err) begin
			$display("ERROR %0t: ack %b err %b, expected err %b at address %h",
				$time, obs_ack, obs_err, exp_err, cur_adr);
			errors++;
		end
		if (chk_dat && obs_dat !== exp_dat) begin
			$display("ERROR %0t: read data %h, expected %h at address %h",
				$time, obs_dat, exp_dat, cur_adr);
			errors++;
		end
		if (chk_lat && obs_lat != FIRST_LAT) begin
			$display("ERROR %0t: response after %0d cycles, expected %0d",
				$time, obs_lat, FIRST_LAT);
			errors++;
		end
	end

	initial begin
		repeat (RESET_CYC) @(posedge clk);
		rstn <= 1'b1;
		// Idle bus stays quiet
		repeat (4) begin
			@(negedge clk);
			if (ack_o || err_o) begin
				$display("ERROR %0t: response with no request after reset", $time);
				errors++;
			end
		end
		@(posedge clk);
		// Target 0, first request also checks latency
		bus_access(T0_BASE, 1'b1, 4'hF, 32'hA5A5_1234, 1'b1);
		bus_access(T0_BASE, 1'b0, 4'hF, '0, 1'b0);
		bus_access(T0_BASE, 1'b1, 4'h5, 32'h0BAD_F00D, 1'b0);
		bus_access(T0_BASE, 1'b0, 4'hF, '0, 1'b0);
		bus_access(T0_LIMIT - 3, 1'b1, 4'hF, 32'h1357_9BDF, 1'b0);
		bus_access(T0_LIMIT - 3, 1'b1, 4'h8, 32'hEE00_0000, 1'b0);
		bus_access(T0_LIMIT - 3, 1'b0, 4'hF, '0, 1'b0);
		// Target 1 base and limit words
		bus_access(T1_BASE, 1'b1, 4'hF, 32'hCAFE_0001, 1'b0);
		bus_access(T1_BASE, 1'b1, 4'h2, 32'h0000_7700, 1'b0);
		bus_access(T1_BASE, 1'b0, 4'hF, '0, 1'b0);
		bus_access(T1_LIMIT - 3, 1'b1, 4'hF, 32'h2468_ACE0, 1'b0);
		bus_access(T1_LIMIT - 3, 1'b1, 4'hC, 32'h9999_0000, 1'b0);
		bus_access(T1_LIMIT - 3, 1'b0, 4'hF, '0, 1'b0);
		bus_access(T0_BASE, 1'b0, 4'hF, '0, 1'b0);
		// Unmapped space
		bus_access(T0_LIMIT + 1, 1'b1, 4'hF, 32'hDEAD_0000, 1'b0);
		bus_access(T0_LIMIT + 1, 1'b0, 4'hF, '0, 1'b0);
		bus_access(T1_LIMIT + 1, 1'b1, 4'hF, 32'hDEAD_0001, 1'b0);
		bus_access(T1_LIMIT + 1, 1'b0, 4'hF, '0, 1'b0);
		bus_access(32'h0000_0800, 1'b1, 4'hF, 32'hDEAD_0002, 1'b0);
		bus_access(32'h0000_0800, 1'b0, 4'hF, '0, 1'b0);
		bus_access(32'hFFFF_FFFC, 1'b1, 4'hF, 32'hDEAD_0003, 1'b0);
		bus_access(32'hFFFF_FFFC, 1'b0, 4'hF, '0, 1'b0);
		// Known contents in both RAMs
		for (int i = 0; i < T0_WORDS; i++) begin
			bus_access(T0_BASE + 4 * i, 1'b1, 4'hF, $random(seed), 1'b0);
		end
		for (int i = 0; i < T1_WORDS; i++) begin
			bus_access(T1_BASE + 4 * i, 1'b1, 4'hF, $random(seed), 1'b0);
		end
		repeat (N_RANDOM) random_access();
		// Final sweep, no word disturbed by the other window or by ERR writes
		for (int i = 0; i < T0_WORDS; i++) begin
			bus_access(T0_BASE + 4 * i, 1'b0, 4'hF, '0, 1'b0);
		end
		for (int i = 0; i < T1_WORDS; i++) begin
			bus_access(T1_BASE + 4 * i, 1'b0, 4'hF, '0, 1'b0);
		end
		$display("Run complete with %0d error(s)", errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog sized from the transaction count
	initial begin
		#((N_TXN * RESP_MAX + RESET_CYC) * CLK_NS);
		$display("Watchdog expired before all transactions finished");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sim/wb_ic_props.sv */
/*
 * Concurrent assertions on the interconnect bus behavior,
 * bound into wb_ic_1x2
 */
`timescale 1ns/1ps

module wb_ic_props (
	input logic clk,
	input logic rstn,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic err_i,
	input logic t0_stb_i,
	input logic t1_stb_i
);

	// ACK and ERR are exclusive
	a_resp_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(ack_i && err_i))
		else $error("ack_o and err_o high together");

	// Responses only inside an active strobe
	a_resp_in_stb: assert property (@(posedge clk) disable iff (!rstn)
		(ack_i || err_i) |-> (cyc_i && stb_i))
		else $error("response without cyc_i and stb_i");

	// At most one RAM target strobed
	a_one_target: assert property (@(posedge clk) disable iff (!rstn)
		!(t0_stb_i && t1_stb_i))
		else $error("both target strobes high");

	// Single-cycle responses
	a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
		ack_i |=> !ack_i)
		else $error("ack_o longer than one cycle");

	a_err_pulse: assert property (@(posedge clk) disable iff (!rstn)
		err_i |=> !err_i)
		else $error("err_o longer than one cycle");

endmodule

bind wb_ic_1x2 wb_ic_props i_props (
	.clk      (clk),
	.rstn     (rstn),
	.cyc_i    (cyc_i),
	.stb_i    (stb_i),
	.ack_i    (ack_o),
	.err_i    (err_o),
	.t0_stb_i (t0_stb_o),
	.t1_stb_i (t1_stb_o)
);
